// ==== build.f ====
+incdir+testbench
hdl/core_cfg_pkg.sv
hdl/pipe_types_pkg.sv
hdl/mul_unit.sv
hdl/exec_pipe.sv
hdl/reg_file.sv
hdl/backend_ctrl.sv
hdl/backend.sv
testbench/backend_asserts.sv
testbench/backend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation passed

SOURCES := $(wildcard hdl/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/backend_tb_model.svh ====
`ifndef BACKEND_TB_MODEL_SVH
`define BACKEND_TB_MODEL_SVH

	localparam int ROM_DEPTH = 2 ** core_cfg_pkg::PC_W;

	pipe_types_pkg::inst_t rom [ROM_DEPTH];
	int unsigned           prog_len;
	core_cfg_pkg::word_t   model_regs [core_cfg_pkg::NUM_REGS];

	function automatic int unsigned rand_below(input int unsigned n);
		return $urandom % n;
	endfunction

	function automatic int rand_imm();
		return int'($urandom % 65536) - 32768;
	endfunction

	function automatic pipe_types_pkg::op_e rand_alu();
		return pipe_types_pkg::op_e'(1 + rand_below(6)); // add..slt
	endfunction

	function automatic pipe_types_pkg::inst_t make_inst(input int pc,
		input pipe_types_pkg::op_e op, input int rd, input int rs1, input int rs2,
		input int imm, input bit use_imm);
		pipe_types_pkg::inst_t inst;
		inst.op      = op;
		inst.pc      = core_cfg_pkg::pc_t'(pc);
		inst.rd      = core_cfg_pkg::reg_idx_t'(rd);
		inst.rs1     = core_cfg_pkg::reg_idx_t'(rs1);
		inst.rs2     = core_cfg_pkg::reg_idx_t'(rs2);
		inst.imm     = core_cfg_pkg::imm_t'(imm);
		inst.use_imm = use_imm;
		return inst;
	endfunction

	function automatic void clear_rom(input int n);
		for (int i = 0; i < ROM_DEPTH; i++)
			rom[i] = make_inst(i, pipe_types_pkg::OP_NOP, 0, 0, 0, i, 1'b0);
		prog_len = n;
	endfunction

	// r16..r23 loaded first, later pairs never read what they write
	function automatic void gen_alu_pairs(input int n);
		clear_rom(n);
		for (int i = 0; i < n; i++)
			if (i < 8)
				rom[i] = make_inst(i, pipe_types_pkg::OP_ADD, 16 + i, 0, 0, rand_imm(), 1'b1);
			else
				rom[i] = make_inst(i, rand_alu(), 1 + i % 15, 16 + rand_below(8),
					16 + rand_below(8), rand_imm(), rand_below(2) == 1);
	endfunction

	// each source was written 1 to 4 instructions back
	function automatic void gen_dep_chain(input int n);
		clear_rom(n);
		for (int i = 0; i < n; i++)
			rom[i] = make_inst(i, rand_alu(), 1 + i % 5, 1 + (i + 4 - int'(rand_below(4))) % 5,
				1 + (i + 4 - int'(rand_below(4))) % 5, rand_imm(), rand_below(3) == 0);
	endfunction

	// load, multiply, then consumers of r4/r5 right behind
	function automatic void gen_mul(input int n);
		clear_rom(n);
		for (int i = 0; i < n; i++)
			case (i % 4)
				0: rom[i] = make_inst(i, pipe_types_pkg::OP_ADD, 1 + rand_below(3), 0, 0,
					rand_imm(), 1'b1);
				1: rom[i] = make_inst(i, pipe_types_pkg::OP_MUL, 4 + rand_below(2),
					1 + rand_below(3), 1 + rand_below(5), 0, 1'b0);
				default: rom[i] = make_inst(i, rand_alu(), 1 + rand_below(5), 4 + rand_below(2),
					1 + rand_below(5), rand_imm(), rand_below(2) == 1);
			endcase
	endfunction

	// br_weight in tenths, branch targets stay forward and inside the program
	function automatic void gen_mixed(input int n, input int br_weight);
		pipe_types_pkg::op_e op;
		int                  span;
		clear_rom(n);
		for (int i = 0; i < n; i++) begin
			span = (n - i < 4) ? n - i : 4;
			if (int'(rand_below(10)) < br_weight) begin
				op = rand_below(2) == 1 ? pipe_types_pkg::OP_BEQ : pipe_types_pkg::OP_BNE;
				rom[i] = make_inst(i, op, 0, rand_below(8), rand_below(8),
					1 + rand_below(span), 1'b0);
			end else begin
				op = pipe_types_pkg::op_e'(rand_below(8)); // nop..mul
				rom[i] = make_inst(i, op, rand_below(8), rand_below(8), rand_below(8),
					rand_imm(), rand_below(2) == 1);
			end
		end
	endfunction

	// architectural step, r0 is never written
	function automatic void model_step(input pipe_types_pkg::inst_t in,
		output core_cfg_pkg::reg_idx_t rd, output core_cfg_pkg::word_t data,
		output core_cfg_pkg::pc_t next_pc);
		core_cfg_pkg::word_t a;
		core_cfg_pkg::word_t b;
		logic                taken;
		a       = model_regs[in.rs1];
		b       = in.use_imm ? core_cfg_pkg::word_t'($signed(in.imm)) : model_regs[in.rs2];
		rd      = in.rd;
		data    = '0;
		next_pc = in.pc + 1'b1;
		case (in.op)
			pipe_types_pkg::OP_ADD: data = a + b;
			pipe_types_pkg::OP_SUB: data = a - b;
			pipe_types_pkg::OP_AND: data = a & b;
			pipe_types_pkg::OP_OR:  data = a | b;
			pipe_types_pkg::OP_XOR: data = a ^ b;
			pipe_types_pkg::OP_SLT: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			pipe_types_pkg::OP_MUL: data = a * b; // low word only
			pipe_types_pkg::OP_BEQ, pipe_types_pkg::OP_BNE: begin
				rd    = '0;
				taken = (in.op == pipe_types_pkg::OP_BEQ) ? (a == b) : (a != b);
				if (taken)
					next_pc = in.pc + core_cfg_pkg::pc_t'(in.imm);
			end
			default: rd = '0;
		endcase
		if (rd != '0)
			model_regs[rd] = data;
	endfunction

`endif

// ==== testbench/backend_tb.sv ====
`timescale 1ns/10ps

module backend_tb;

	localparam int          CLK_PERIOD    = 10;
	localparam int          DRIVE_DELAY   = 1;
	localparam int          MARGIN_CYCLES = 40;
	localparam int unsigned RAND_SEED     = 32'hed1ecc5c;

	typedef enum {PROG_ALU, PROG_DEP, PROG_MUL, PROG_BRANCH, PROG_RANDOM} prog_kind_e;

	logic                          clk;
	logic                          rst_n_i;
	pipe_types_pkg::inst_t [1:0]   inst_i;
	logic [1:0]                    inst_valid_i;
	logic [1:0]                    issue_num_o;
	logic                          redirect_o;
	core_cfg_pkg::pc_t             redirect_pc_o;
	pipe_types_pkg::commit_t [1:0] commit_o;

	core_cfg_pkg::pc_t fetch_pc, exp_pc, redir_pc_q;
	logic              run_q, redir_q;
	logic [1:0]        take_q;
	bit                test_active;
	bit                dual_expected; // every valid pair must issue together
	int unsigned       errors, commits, tests_run, test_cycles, cycle_limit;
	string             test_name;

	`include "backend_tb_model.svh"

	backend backend_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.inst_i        (inst_i),
		.inst_valid_i  (inst_valid_i),
		.issue_num_o   (issue_num_o),
		.redirect_o    (redirect_o),
		.redirect_pc_o (redirect_pc_o),
		.commit_o      (commit_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic int unsigned failures();
		return errors + backend_i.backend_asserts_i.fail_cnt;
	endfunction

	task automatic check_commit(input pipe_types_pkg::commit_t c);
		core_cfg_pkg::reg_idx_t rd;
		core_cfg_pkg::word_t    data;
		core_cfg_pkg::pc_t      next_pc;
		commits++;
		assert (exp_pc < prog_len) else begin
			$display("commit of pc %0d arrived after the program ended", c.pc);
			errors++;
		end
		if (exp_pc < prog_len) begin
			model_step(rom[exp_pc], rd, data, next_pc);
			assert (c.pc == exp_pc) else begin
				$display("CHECK FAILED commit_o.pc got %h expected %h", c.pc, exp_pc);
				errors++;
			end
			assert (c.rd == rd) else begin
				$display("CHECK FAILED commit_o.rd got %h expected %h (pc %h)", c.rd, rd, c.pc);
				errors++;
			end
			assert (c.data == data) else begin
				$display("CHECK FAILED commit_o.data got %h expected %h (pc %h)", c.data, data,
					c.pc);
				errors++;
			end
			exp_pc = next_pc;
		end
	endtask

	// mid-cycle sample of the dut outputs
	always @(negedge clk) begin
		run_q      = rst_n_i;
		take_q     = issue_num_o;
		redir_q    = redirect_o;
		redir_pc_q = redirect_pc_o;
		if (rst_n_i && test_active) begin
			test_cycles++;
			// independent pairs always dual-issue
			if (dual_expected && inst_valid_i == 2'b11)
				assert (issue_num_o == 2'd2) else begin
					$display("CHECK FAILED issue_num_o got %h expected %h", issue_num_o, 2'd2);
					errors++;
				end
			// lower pc is the older commit
			if (commit_o[0].valid && commit_o[1].valid && commit_o[1].pc < commit_o[0].pc) begin
				check_commit(commit_o[1]);
				check_commit(commit_o[0]);
			end else begin
				if (commit_o[0].valid)
					check_commit(commit_o[0]);
				if (commit_o[1].valid)
					check_commit(commit_o[1]);
			end
		end
	end

	// frontend advances by what was taken at this edge
	always @(posedge clk) begin
		#DRIVE_DELAY;
		if (!run_q)
			fetch_pc = '0;
		else if (redir_q)
			fetch_pc = redir_pc_q;
		else
			fetch_pc = fetch_pc + core_cfg_pkg::pc_t'(take_q);
		for (int s = 0; s < 2; s++) begin
			inst_i[s]       = rom[core_cfg_pkg::pc_t'(fetch_pc + s)];
			inst_valid_i[s] = run_q && (fetch_pc + s < prog_len);
		end
	end

	task automatic run_program(input string name, input prog_kind_e kind, input int n);
		int unsigned fail_before;
		int unsigned commits_before;
		@(posedge clk);
		#DRIVE_DELAY;
		rst_n_i = 1'b0;
		case (kind)
			PROG_ALU:    gen_alu_pairs(n);
			PROG_DEP:    gen_dep_chain(n);
			PROG_MUL:    gen_mul(n);
			PROG_BRANCH: gen_mixed(n, 4);
			default:     gen_mixed(n, 2);
		endcase
		for (int r = 0; r < core_cfg_pkg::NUM_REGS; r++)
			model_regs[r] = '0;
		exp_pc         = '0;
		test_name      = name;
		dual_expected  = (kind == PROG_ALU);
		test_cycles    = 0;
		cycle_limit    = n * (core_cfg_pkg::MUL_CYCLES + 6) + MARGIN_CYCLES;
		fail_before    = failures();
		commits_before = commits;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst_n_i     = 1'b1;
		test_active = 1'b1;
		while (exp_pc < prog_len)
			@(negedge clk);
		repeat (8) @(negedge clk); // any stray commit shows up here
		test_active = 1'b0;
		tests_run++;
		$display("test %s: %0d instructions, %0d commits, %0d cycles, %s", name, n,
			commits - commits_before, test_cycles, (failures() == fail_before) ? "ok" : "errors");
	endtask

	initial begin : watchdog
		while (!(test_active && test_cycles > cycle_limit))
			@(posedge clk);
		$display("timeout, program %s still running after %0d cycles", test_name, cycle_limit);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		void'($urandom(RAND_SEED));
		clk           = 1'b0;
		rst_n_i       = 1'b0;
		inst_i        = '0;
		inst_valid_i  = '0;
		run_q         = 1'b0;
		take_q        = '0;
		redir_q       = 1'b0;
		redir_pc_q    = '0;
		fetch_pc      = '0;
		exp_pc        = '0;
		prog_len      = 0;
		test_active   = 1'b0;
		dual_expected = 1'b0;
		errors        = 0;
		commits       = 0;
		tests_run     = 0;
		test_cycles   = 0;
		cycle_limit   = 0;
		run_program("alu_pairs", PROG_ALU, 40);
		run_program("dep_chain", PROG_DEP, 40);
		run_program("mul", PROG_MUL, 32);
		run_program("branch", PROG_BRANCH, 40);
		for (int t = 0; t < 3; t++)
			run_program($sformatf("random_%0d", t), PROG_RANDOM, 60);
		$display("%0d tests, %0d commits checked, %0d failed checks", tests_run, commits,
			failures());
		if (failures() == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== testbench/backend_asserts.sv ====
`timescale 1ns/10ps

module backend_asserts (
	input logic                          clk,
	input logic                          rst_n_i,
	input logic [1:0]                    inst_valid_i,
	input logic [1:0]                    issue_num_i,
	input logic                          redirect_i,
	input pipe_types_pkg::commit_t [1:0] commit_i
);

	int unsigned fail_cnt = 0; // read by the testbench summary

	issue_le_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
		issue_num_i <= 2'($countones(inst_valid_i)))
	else begin
		$error("issue_num_o larger than the number of valid slots");
		fail_cnt++;
	end

	// strobe, the branch leaves m1 after one cycle
	redirect_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
		redirect_i |=> !redirect_i)
	else begin
		$error("redirect_o high for more than one cycle");
		fail_cnt++;
	end

	no_issue_on_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
		redirect_i |-> issue_num_i == 2'd0)
	else begin
		$error("instruction issued during redirect");
		fail_cnt++;
	end

	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n_i) |-> !redirect_i && !commit_i[0].valid && !commit_i[1].valid &&
			issue_num_i == 2'd0)
	else begin
		$error("activity in the first cycle after reset");
		fail_cnt++;
	end

	distinct_commit_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
		commit_i[0].valid && commit_i[1].valid |-> commit_i[0].pc != commit_i[1].pc)
	else begin
		$error("both pipes committed the same pc");
		fail_cnt++;
	end

endmodule

bind backend backend_asserts backend_asserts_i (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.inst_valid_i (inst_valid_i),
	.issue_num_i  (issue_num_o),
	.redirect_i   (redirect_o),
	.commit_i     (commit_o)
);

// ==== hdl/backend.sv ====
`timescale 1ns/10ps

module backend (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  pipe_types_pkg::inst_t [1:0]       inst_i,
	input  logic [1:0]                        inst_valid_i,
	output logic [1:0]                        issue_num_o,
	output logic                              redirect_o,
	output core_cfg_pkg::pc_t                 redirect_pc_o,
	output pipe_types_pkg::commit_t [1:0]     commit_o
);

	logic [1:0]                       issue;
	logic                             revert, rvt_m1;
	pipe_types_pkg::fwd_sel_t [1:0]   fwd_sel;
	pipe_types_pkg::fwd_bus_t [1:0]   fwd_bus;
	pipe_types_pkg::stage_vec_t [1:0] stall_req, stall_vec, clr_vec;
	pipe_types_pkg::stage_t [1:0]     entry;
	logic [1:0]                       pipe_issue;
	core_cfg_pkg::reg_idx_t [3:0]     r_addr;
	core_cfg_pkg::word_t [3:0]        r_data;
	logic [1:0]                       w_en;
	core_cfg_pkg::reg_idx_t [1:0]     w_addr;
	core_cfg_pkg::word_t [1:0]        w_data;

	backend_ctrl backend_ctrl_i (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.fwd_i        (fwd_bus),
		.stall_req_i  (stall_req),
		.br_clr_i     (redirect_o),
		.rvt_m1_i     (rvt_m1),
		.issue_num_o  (issue_num_o),
		.issue_o      (issue),
		.revert_o     (revert),
		.fwd_sel_o    (fwd_sel),
		.stall_vec_o  (stall_vec),
		.clr_vec_o    (clr_vec)
	);

	// read ports 0,1 for slot 0 and 2,3 for slot 1
	assign r_addr = {inst_i[1].rs2, inst_i[1].rs1, inst_i[0].rs2, inst_i[0].rs1};

	reg_file reg_file_i (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.w_en_i   (w_en),
		.w_addr_i (w_addr),
		.w_data_i (w_data),
		.r_addr_i (r_addr),
		.r_data_o (r_data)
	);

	// pipe p takes slot p, or the other slot when the pair is swapped
	for (genvar p = 0; p < 2; p++) begin : g_entry
		logic slot;
		assign slot = revert ^ p[0];
		always_comb begin
			entry[p].valid        = issue[slot];
			entry[p].inst         = inst_i[slot];
			entry[p].a            = r_data[{slot, 1'b0}];
			entry[p].b            = r_data[{slot, 1'b1}];
			entry[p].result       = '0;
			entry[p].result_ready = 1'b0;
			entry[p].rvt          = revert;
		end
		assign pipe_issue[p] = issue[slot];
		assign w_en[p]   = commit_o[p].valid && commit_o[p].rd != '0;
		assign w_addr[p] = commit_o[p].rd;
		assign w_data[p] = commit_o[p].data;
	end

	exec_pipe #(.MAIN_PIPE(1'b1)) exec_pipe_0 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.issue_i     (pipe_issue[0]),
		.entry_i     (entry[0]),
		.fwd_sel_i   (fwd_sel[0]),
		.fwd_all_i   (fwd_bus),
		.stall_vec_i (stall_vec[0]),
		.clr_vec_i   (clr_vec[0]),
		.fwd_o       (fwd_bus[0]),
		.stall_req_o (stall_req[0]),
		.br_clr_o    (redirect_o),    // one cycle, branch sits in m1 once
		.br_target_o (redirect_pc_o),
		.rvt_m1_o    (rvt_m1),
		.commit_o    (commit_o[0])
	);

	exec_pipe #(.MAIN_PIPE(1'b0)) exec_pipe_1 (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.issue_i     (pipe_issue[1]),
		.entry_i     (entry[1]),
		.fwd_sel_i   (fwd_sel[1]),
		.fwd_all_i   (fwd_bus),
		.stall_vec_i (stall_vec[1]),
		.clr_vec_i   (clr_vec[1]),
		.fwd_o       (fwd_bus[1]),
		.stall_req_o (stall_req[1]),
		.br_clr_o    (),              // no branch unit here
		.br_target_o (),
		.rvt_m1_o    (),
		.commit_o    (commit_o[1])
	);

endmodule

// ==== hdl/backend_ctrl.sv ====
`timescale 1ns/10ps

module backend_ctrl (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  pipe_types_pkg::inst_t [1:0]         inst_i,
	input  logic [1:0]                          inst_valid_i,
	input  pipe_types_pkg::fwd_bus_t [1:0]      fwd_i,
	input  pipe_types_pkg::stage_vec_t [1:0]    stall_req_i,
	input  logic                                br_clr_i,
	input  logic                                rvt_m1_i,
	output logic [1:0]                          issue_num_o,
	output logic [1:0]                          issue_o,   // per slot
	output logic                                revert_o,
	output pipe_types_pkg::fwd_sel_t [1:0]      fwd_sel_o, // per pipe
	output pipe_types_pkg::stage_vec_t [1:0]    stall_vec_o,
	output pipe_types_pkg::stage_vec_t [1:0]    clr_vec_o
);

	logic                         revert_q; // swap bit of the pair now in EX
	logic [2:0]                   young;    // younger pipe per stage
	pipe_types_pkg::stage_vec_t   stall_all;
	pipe_types_pkg::fwd_sel_t [1:0] slot_sel;
	logic [1:0]                   rdy_a, rdy_b, haz, main;
	logic                         raw01, waw01;

	// scan oldest to youngest so the last hit wins
	function automatic void find_src(input core_cfg_pkg::reg_idx_t rs, input logic [2:0] yng,
		input pipe_types_pkg::fwd_bus_t [1:0] bus,
		output pipe_types_pkg::fwd_src_t src, output logic rdy);
		logic p;
		src = '0;
		rdy = 1'b1;
		for (int s = 2; s >= 0; s--) begin
			for (int k = 0; k < 2; k++) begin
				p = (k == 1) ? yng[s] : ~yng[s];
				if (rs != '0 && bus[p].valid[s] && bus[p].rd[s] == rs) begin
					src.hit   = 1'b1;
					src.pipe  = p;
					src.stage = 2'(s + 1); // it moves one stage before the consumer reads it
					rdy       = bus[p].ready[s];
				end
			end
		end
	endfunction

	// m2 pair order does not matter, issue rules forbid a same-rd pair
	assign young = {1'b1, ~rvt_m1_i, ~revert_q};

	// a request at level l stalls l and everything before it, in both pipes
	always_comb begin
		for (int l = 0; l < 3; l++) begin
			stall_all[l] = 1'b0;
			for (int r = l; r < 3; r++)
				stall_all[l] |= stall_req_i[0][r] | stall_req_i[1][r];
		end
	end

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			find_src(inst_i[s].rs1, young, fwd_i, slot_sel[s].a, rdy_a[s]);
			find_src(inst_i[s].rs2, young, fwd_i, slot_sel[s].b, rdy_b[s]);
			// only a multiply can be not ready
			haz[s]  = (slot_sel[s].a.hit & ~rdy_a[s]) |
				(~inst_i[s].use_imm & slot_sel[s].b.hit & ~rdy_b[s]);
			main[s] = pipe_types_pkg::needs_main(inst_i[s].op);
		end
	end

	always_comb begin
		raw01 = pipe_types_pkg::writes_rd(inst_i[0].op) && inst_i[0].rd != '0 &&
			(inst_i[1].rs1 == inst_i[0].rd ||
			(!inst_i[1].use_imm && inst_i[1].rs2 == inst_i[0].rd));
		waw01 = pipe_types_pkg::writes_rd(inst_i[0].op) &&
			pipe_types_pkg::writes_rd(inst_i[1].op) &&
			inst_i[0].rd != '0 && inst_i[0].rd == inst_i[1].rd;
	end

	assign issue_o[0] = inst_valid_i[0] & ~stall_all[0] & ~br_clr_i & ~haz[0];
	assign issue_o[1] = issue_o[0] & inst_valid_i[1] & ~raw01 & ~waw01 &
		~(main[0] & main[1]) & ~haz[1];
	assign revert_o    = issue_o[1] & main[1] & ~main[0];
	assign issue_num_o = {1'b0, issue_o[0]} + {1'b0, issue_o[1]};

	assign fwd_sel_o[0] = slot_sel[revert_o];
	assign fwd_sel_o[1] = slot_sel[~revert_o];

	assign stall_vec_o[0] = stall_all;
	assign stall_vec_o[1] = stall_all;

	// branch in main m1 kills EX, and m1 of pipe 1 when that one is younger
	assign clr_vec_o[0] = {2'b00, br_clr_i};
	assign clr_vec_o[1] = {1'b0, br_clr_i & ~rvt_m1_i, br_clr_i};

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i)
			revert_q <= 1'b0;
		else if (!stall_all[0])
			revert_q <= revert_o;
	end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
	input  logic                              clk,
	input  logic                              rst_n_i,
	input  logic [1:0]                        w_en_i,
	input  core_cfg_pkg::reg_idx_t [1:0]      w_addr_i,
	input  core_cfg_pkg::word_t [1:0]         w_data_i,
	input  core_cfg_pkg::reg_idx_t [3:0]      r_addr_i,
	output core_cfg_pkg::word_t [3:0]         r_data_o
);

	core_cfg_pkg::word_t regs [core_cfg_pkg::NUM_REGS];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < core_cfg_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else begin
			for (int w = 0; w < 2; w++)
				if (w_en_i[w] && w_addr_i[w] != '0)
					regs[w_addr_i[w]] <= w_data_i[w];
		end
	end

	// write-through so an issuing instruction sees the wb value
	always_comb begin
		for (int r = 0; r < 4; r++) begin
			r_data_o[r] = regs[r_addr_i[r]];
			for (int w = 0; w < 2; w++)
				if (w_en_i[w] && w_addr_i[w] == r_addr_i[r])
					r_data_o[r] = w_data_i[w];
			if (r_addr_i[r] == '0)
				r_data_o[r] = '0; // r0
		end
	end

endmodule

// ==== hdl/exec_pipe.sv ====
`timescale 1ns/10ps

module exec_pipe #(
	parameter bit MAIN_PIPE = 1'b0 // carries multiplier and branch unit
) (
	input  logic                           clk,
	input  logic                           rst_n_i,
	input  logic                           issue_i,
	input  pipe_types_pkg::stage_t         entry_i,
	input  pipe_types_pkg::fwd_sel_t       fwd_sel_i,
	input  pipe_types_pkg::fwd_bus_t [1:0] fwd_all_i,
	input  pipe_types_pkg::stage_vec_t     stall_vec_i,
	input  pipe_types_pkg::stage_vec_t     clr_vec_i,
	output pipe_types_pkg::fwd_bus_t       fwd_o,
	output pipe_types_pkg::stage_vec_t     stall_req_o,
	output logic                           br_clr_o,
	output core_cfg_pkg::pc_t              br_target_o,
	output logic                           rvt_m1_o,
	output pipe_types_pkg::commit_t        commit_o
);

	pipe_types_pkg::stage_t   st_ex, st_m1, st_m2, st_wb;
	pipe_types_pkg::stage_t   ex_out, m1_out;
	pipe_types_pkg::stage_t [3:0] view;
	pipe_types_pkg::fwd_sel_t ex_sel;
	core_cfg_pkg::word_t      imm_ext, mul_product;
	logic                     taken, mul_start, mul_busy, mul_done, m1_is_mul;

	function automatic core_cfg_pkg::word_t pick(input pipe_types_pkg::fwd_src_t src,
		input core_cfg_pkg::word_t own, input pipe_types_pkg::fwd_bus_t [1:0] bus);
		return src.hit ? bus[src.pipe].data[src.stage] : own;
	endfunction

	assign imm_ext = {{(core_cfg_pkg::XLEN - core_cfg_pkg::IMM_W){st_ex.inst.imm[core_cfg_pkg::IMM_W-1]}},
		st_ex.inst.imm};

	// EX: resolve operands, then alu
	always_comb begin
		ex_out   = st_ex;
		ex_out.a = pick(ex_sel.a, st_ex.a, fwd_all_i);
		ex_out.b = st_ex.inst.use_imm ? imm_ext : pick(ex_sel.b, st_ex.b, fwd_all_i);
		taken    = 1'b0;
		unique case (st_ex.inst.op)
			pipe_types_pkg::OP_ADD: ex_out.result = ex_out.a + ex_out.b;
			pipe_types_pkg::OP_SUB: ex_out.result = ex_out.a - ex_out.b;
			pipe_types_pkg::OP_AND: ex_out.result = ex_out.a & ex_out.b;
			pipe_types_pkg::OP_OR:  ex_out.result = ex_out.a | ex_out.b;
			pipe_types_pkg::OP_XOR: ex_out.result = ex_out.a ^ ex_out.b;
			pipe_types_pkg::OP_SLT: ex_out.result = core_cfg_pkg::word_t'($signed(ex_out.a) < $signed(ex_out.b));
			pipe_types_pkg::OP_BEQ: taken = MAIN_PIPE && (ex_out.a == ex_out.b);
			pipe_types_pkg::OP_BNE: taken = MAIN_PIPE && (ex_out.a != ex_out.b);
			default:                ex_out.result = '0; // nop, mul finishes in m1
		endcase
		if (pipe_types_pkg::is_branch(st_ex.inst.op))
			ex_out.result = core_cfg_pkg::word_t'(taken);
		ex_out.result_ready = (st_ex.inst.op != pipe_types_pkg::OP_MUL);
	end

	// M1: multiply sequencing
	assign m1_is_mul = st_m1.valid && st_m1.inst.op == pipe_types_pkg::OP_MUL && !st_m1.result_ready;
	assign mul_start = MAIN_PIPE && m1_is_mul && !mul_busy;

	generate
		if (MAIN_PIPE) begin : g_mul
			mul_unit mul_unit_i (
				.clk       (clk),
				.rst_n_i   (rst_n_i),
				.start_i   (mul_start),
				.a_i       (st_m1.a),
				.b_i       (st_m1.b),
				.busy_o    (mul_busy),
				.done_o    (mul_done),
				.product_o (mul_product)
			);
		end else begin : g_no_mul
			assign mul_busy    = 1'b0;
			assign mul_done    = 1'b0;
			assign mul_product = '0;
		end
	endgenerate

	always_comb begin
		m1_out = st_m1;
		if (m1_is_mul && mul_done) begin
			m1_out.result       = mul_product;
			m1_out.result_ready = 1'b1;
		end
	end

	assign stall_req_o = {1'b0, MAIN_PIPE && m1_is_mul && !m1_out.result_ready, 1'b0};
	assign br_clr_o    = MAIN_PIPE && st_m1.valid && pipe_types_pkg::is_branch(st_m1.inst.op) &&
		st_m1.result[0];
	assign br_target_o = st_m1.inst.pc + core_cfg_pkg::pc_t'(st_m1.inst.imm);
	assign rvt_m1_o    = st_m1.rvt;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			st_ex  <= '0;
			ex_sel <= '0;
		end else if (stall_vec_i[0]) begin
			// keep the resolved operands, producers move on while we wait
			st_ex       <= ex_out;
			st_ex.valid <= st_ex.valid & ~clr_vec_i[0];
			ex_sel      <= '0;
		end else begin
			st_ex       <= entry_i;
			st_ex.valid <= issue_i;
			ex_sel      <= fwd_sel_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			st_m1 <= '0;
		end else if (stall_vec_i[1]) begin
			st_m1       <= m1_out;
			st_m1.valid <= st_m1.valid & ~clr_vec_i[1];
		end else if (stall_vec_i[0] || clr_vec_i[0]) begin
			st_m1.valid <= 1'b0; // bubble
		end else begin
			st_m1 <= ex_out;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			st_m2 <= '0;
			st_wb <= '0;
		end else begin
			if (stall_vec_i[2])
				st_m2.valid <= st_m2.valid & ~clr_vec_i[2];
			else if (stall_vec_i[1] || clr_vec_i[1])
				st_m2.valid <= 1'b0;
			else
				st_m2 <= m1_out;
			if (stall_vec_i[2] || clr_vec_i[2])
				st_wb.valid <= 1'b0;
			else
				st_wb <= st_m2;
		end
	end

	// forwarding sources, index is the stage
	assign view = {st_wb, st_m2, m1_out, ex_out};

	always_comb begin
		for (int s = 0; s < 4; s++) begin
			fwd_o.valid[s] = view[s].valid && pipe_types_pkg::writes_rd(view[s].inst.op);
			fwd_o.rd[s]    = view[s].inst.rd;
			fwd_o.ready[s] = view[s].result_ready;
			fwd_o.data[s]  = view[s].result;
		end
	end

	// branches and nops commit without a destination
	always_comb begin
		commit_o.valid = st_wb.valid;
		commit_o.pc    = st_wb.inst.pc;
		commit_o.rd    = pipe_types_pkg::writes_rd(st_wb.inst.op) ? st_wb.inst.rd : '0;
		commit_o.data  = pipe_types_pkg::writes_rd(st_wb.inst.op) ? st_wb.result : '0;
	end

endmodule

// ==== hdl/mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                start_i,
	input  core_cfg_pkg::word_t a_i,
	input  core_cfg_pkg::word_t b_i,
	output logic                busy_o,
	output logic                done_o,
	output core_cfg_pkg::word_t product_o
);

	typedef enum logic {MUL_IDLE, MUL_RUN} mul_state_e;

	mul_state_e                      state_q;
	logic [core_cfg_pkg::MUL_CNT_W-1:0] cnt_q;
	core_cfg_pkg::word_t             a_q, b_q, acc_q;
	core_cfg_pkg::word_t             op_a, op_b, partial, sum;

	// first chunk is taken straight from the inputs in the start cycle
	assign op_a = (state_q == MUL_IDLE) ? a_i : a_q;
	assign op_b = (state_q == MUL_IDLE) ? b_i : b_q;

	always_comb begin
		partial = '0;
		for (int i = 0; i < core_cfg_pkg::MUL_CHUNK; i++)
			if (op_b[i])
				partial += op_a << i;
		sum = ((state_q == MUL_IDLE) ? '0 : acc_q) + partial;
	end

	assign busy_o    = (state_q == MUL_RUN);
	assign done_o    = busy_o && cnt_q == core_cfg_pkg::MUL_CNT_W'(core_cfg_pkg::MUL_CYCLES - 1);
	assign product_o = sum;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= MUL_IDLE;
			cnt_q   <= '0;
		end else if (state_q == MUL_IDLE) begin
			if (start_i) begin
				state_q <= MUL_RUN;
				cnt_q   <= 1;
			end
		end else if (done_o) begin
			state_q <= MUL_IDLE;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i || (busy_o && !done_o)) begin
			a_q   <= op_a << core_cfg_pkg::MUL_CHUNK;
			b_q   <= op_b >> core_cfg_pkg::MUL_CHUNK;
			acc_q <= sum;
		end
	end

endmodule

// ==== hdl/pipe_types_pkg.sv ====
package pipe_types_pkg;

	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT, // signed
		OP_MUL, // main pipe only
		OP_BEQ, // main pipe only
		OP_BNE  // main pipe only
	} op_e;

	typedef struct packed {
		op_e                   op;
		core_cfg_pkg::pc_t     pc;
		core_cfg_pkg::reg_idx_t rs1;
		core_cfg_pkg::reg_idx_t rs2;
		core_cfg_pkg::reg_idx_t rd;
		core_cfg_pkg::imm_t    imm;   // branch offset or alu operand
		logic                  use_imm;
	} inst_t;

	// one operand source; stage is where the producer sits while the consumer is in EX
	typedef struct packed {
		logic       hit;
		logic       pipe;
		logic [1:0] stage; // 1 m1, 2 m2, 3 wb
	} fwd_src_t;

	typedef struct packed {
		fwd_src_t a;
		fwd_src_t b;
	} fwd_sel_t;

	typedef struct packed {
		logic                valid;
		inst_t               inst;
		core_cfg_pkg::word_t a;
		core_cfg_pkg::word_t b;
		core_cfg_pkg::word_t result; // branch keeps its taken flag in bit 0
		logic                result_ready;
		logic                rvt;    // pair was swapped at issue
	} stage_t;

	typedef struct packed {
		logic                   valid;
		core_cfg_pkg::pc_t      pc;
		core_cfg_pkg::reg_idx_t rd;
		core_cfg_pkg::word_t    data;
	} commit_t;

	typedef logic [2:0] stage_vec_t; // bit 0 ex, 1 m1, 2 m2

	// index 0 ex, 1 m1, 2 m2, 3 wb
	typedef struct packed {
		logic [3:0]                        valid;
		core_cfg_pkg::reg_idx_t [3:0]      rd;
		logic [3:0]                        ready;
		core_cfg_pkg::word_t [3:0]         data;
	} fwd_bus_t;

	function automatic logic is_branch(input op_e op);
		return (op == OP_BEQ) || (op == OP_BNE);
	endfunction

	function automatic logic needs_main(input op_e op);
		return (op == OP_MUL) || is_branch(op);
	endfunction

	function automatic logic writes_rd(input op_e op);
		return (op != OP_NOP) && !is_branch(op);
	endfunction

endpackage

// ==== hdl/core_cfg_pkg.sv ====
package core_cfg_pkg;

	localparam int XLEN       = 32;
	localparam int NUM_REGS   = 32;
	localparam int REG_IDX_W  = 5;
	localparam int PC_W       = 8;  // instruction index, not a byte address
	localparam int IMM_W      = 16;

	// iterative multiply, cycles spent in M1
	localparam int MUL_CYCLES = 4;
	localparam int MUL_CHUNK  = XLEN / MUL_CYCLES; // multiplier bits per cycle
	localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

	typedef logic [XLEN-1:0]      word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [PC_W-1:0]      pc_t;
	typedef logic [IMM_W-1:0]     imm_t; // signed, sign extended at use

endpackage
